// ==== hw/icache_pkg.sv ====
// shared address geometry for the direct-mapped instruction cache
// every cache module imports this package to size its ports and to
// split a byte address into tag, set, word and byte fields
// a line holds four 32-bit words and the cache has 64 sets

package icache_pkg;

	// byte address width seen by the requester and the memory
	localparam int addr_width = 32;

	// width of one instruction word
	localparam int data_width = 32;

	// low address bits that select a byte inside a word
	localparam int byte_ofs_width = 2;

	// word index inside a line, four words per line
	localparam int word_idx_width = 2;
	localparam int words_per_line = 1 << word_idx_width;

	// set index, 64 sets in total
	localparam int set_idx_width = 6;

	// whatever is left above the set index is kept as the tag
	localparam int tag_width = addr_width - set_idx_width - word_idx_width - byte_ofs_width;

	// one address word, seen either as a plain vector or split into its fields
	typedef union packed {
		logic [addr_width-1:0] raw;
		struct packed {
			logic [tag_width-1:0]      tag;
			logic [set_idx_width-1:0]  set_idx;
			logic [word_idx_width-1:0] word_idx;
			logic [byte_ofs_width-1:0] byte_ofs;
		} fields;
	} cache_addr_t;

endpackage

// ==== hw/sram_1r1w.sv ====
// synchronous memory with one read port and one write port
// read data shows up one clock edge after rd_enable is sampled high
// a read and a write to the same address in the same cycle return the new word
// the cache builds both its tag array and its line data array from this block
`timescale 1ns/1ps

module sram_1r1w #(
	parameter int data_width_p = 32,
	parameter int size_p = 1024,
	localparam int addr_width_l = $clog2(size_p)
) (
	input  logic                    clk,
	input  logic                    rd_enable,
	input  logic [addr_width_l-1:0] rd_addr,
	output logic [data_width_p-1:0] rd_data,
	input  logic                    wr_enable,
	input  logic [addr_width_l-1:0] wr_addr,
	input  logic [data_width_p-1:0] wr_data
);

	logic [data_width_p-1:0] mem [size_p];

	// the array starts out all zero in simulation
	initial
	begin
		for (int i = 0; i < size_p; i++)
		begin
			mem[i] = '0;
		end
		rd_data = '0;
	end

	always @(posedge clk)
	begin
		if (wr_enable)
		begin
			mem[wr_addr] <= wr_data;
		end

		// a read that hits the word being written takes the write data directly
		if (rd_enable && wr_enable && (rd_addr == wr_addr))
		begin
			rd_data <= wr_data;
		end
		else if (rd_enable)
		begin
			rd_data <= mem[rd_addr];
		end
		// with rd_enable low the last read word is held
	end

endmodule

// ==== hw/icache_tag_store.sv ====
// tag array and valid bits of the instruction cache
// a lookup reads the tag of its set, and one cycle later the stored tag
// is compared with the requested one to give a hit or a miss pulse
// the fill controller writes the new tag when a line fill completes
`timescale 1ns/1ps

module icache_tag_store
	import icache_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     lookup,
	input  cache_addr_t              lookup_addr,
	input  logic                     invalidate_all,
	input  logic                     tag_wr,
	input  logic [set_idx_width-1:0] tag_wr_set,
	input  logic [tag_width-1:0]     tag_wr_tag,
	output logic                     hit,
	output logic                     miss
);

	localparam int sets_l = 1 << set_idx_width;

	// one valid flag per set is kept in flops so that a single pulse clears all
	logic [sets_l-1:0] valid_q;

	// lookup in its compare stage
	logic                     lookup_q;
	logic [set_idx_width-1:0] set_q;
	logic [tag_width-1:0]     tag_q;

	// tag read back from the array for the set in the compare stage
	logic [tag_width-1:0] ram_tag;
	logic                 tag_match;

	// the read port follows the lookup, the write port follows the fill
	// a tag written in the same cycle as a lookup to that set comes back
	// through the memory bypass
	sram_1r1w #(
		.data_width_p (tag_width),
		.size_p       (sets_l)
	) u_tag_ram (
		.clk       (clk),
		.rd_enable (lookup),
		.rd_addr   (lookup_addr.fields.set_idx),
		.rd_data   (ram_tag),
		.wr_enable (tag_wr),
		.wr_addr   (tag_wr_set),
		.wr_data   (tag_wr_tag)
	);

	// the tag write lands in the cycle after busy falls, where an invalidate
	// is accepted again, and then the invalidate wins so the new line is
	// dropped together with all the others
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
		end
		else if (invalidate_all)
		begin
			valid_q <= '0;
		end
		else if (tag_wr)
		begin
			valid_q[tag_wr_set] <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lookup_q <= 1'b0;
		end
		else
		begin
			lookup_q <= lookup;
		end
	end

	// set and tag of the lookup are held until the next lookup arrives
	always_ff @(posedge clk)
	begin
		if (lookup)
		begin
			set_q <= lookup_addr.fields.set_idx;
			tag_q <= lookup_addr.fields.tag;
		end
	end

	// the valid flag set by a tag write lands on the same edge that moves
	// a lookup into the compare stage, so both views stay in step
	assign tag_match = valid_q[set_q] && (ram_tag == tag_q);
	assign hit       = lookup_q && tag_match;
	assign miss      = lookup_q && !tag_match;

endmodule

// ==== hw/icache_fill_ctrl.sv ====
// line fill control for the instruction cache
// a miss pulse latches the address, raises busy and sends a line read
// to memory; the four returned words are written into the data array,
// the missed word is kept, and after the last word the tag is written
// and the kept word is returned as the response
`timescale 1ns/1ps

module icache_fill_ctrl
	import icache_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   miss,
	input  cache_addr_t                            miss_addr,
	input  logic                                   mem_data_valid,
	input  logic [data_width-1:0]                  mem_data,
	output logic                                   busy,
	output logic                                   mem_rd,
	output logic [addr_width-1:0]                  mem_addr,
	output logic                                   data_wr,
	output logic [set_idx_width+word_idx_width-1:0] data_wr_addr,
	output logic [data_width-1:0]                  data_wr_data,
	output logic                                   tag_wr,
	output logic [set_idx_width-1:0]               tag_wr_set,
	output logic [tag_width-1:0]                   tag_wr_tag,
	output logic                                   fill_resp_valid,
	output logic [data_width-1:0]                  fill_resp_data
);

	localparam logic state_idle = 1'b0;
	localparam logic state_fill = 1'b1;
	localparam logic [word_idx_width-1:0] last_word_l = word_idx_width'(words_per_line - 1);

	logic                      state_q;
	cache_addr_t               fill_addr_q;
	logic [word_idx_width-1:0] word_cnt_q;

	// a word is taken only while a fill is running
	logic        word_in;
	logic        last_in;
	cache_addr_t line_addr;

	// write side and response registers
	logic                                    data_wr_q;
	logic [set_idx_width+word_idx_width-1:0] data_wr_addr_q;
	logic [data_width-1:0]                   data_wr_data_q;
	logic                                    tag_wr_q;
	logic                                    resp_valid_q;
	logic [data_width-1:0]                   resp_data_q;

	assign word_in = (state_q == state_fill) && mem_data_valid;
	assign last_in = word_in && (word_cnt_q == last_word_l);

	// the memory is always asked for a whole line, so word and byte bits are cleared
	always_comb
	begin
		line_addr = miss_addr;
		line_addr.fields.word_idx = '0;
		line_addr.fields.byte_ofs = '0;
	end

	// a miss can only come up while idle, because requests stop while busy
	assign mem_rd   = miss;
	assign mem_addr = line_addr.raw;
	assign busy     = miss || (state_q == state_fill);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q    <= state_idle;
			word_cnt_q <= '0;
		end
		else if (state_q == state_idle)
		begin
			if (miss)
			begin
				state_q    <= state_fill;
				word_cnt_q <= '0;
			end
		end
		else if (mem_data_valid)
		begin
			// words come back in order, so the counter is also the word index
			word_cnt_q <= word_cnt_q + 1'b1;
			if (word_cnt_q == last_word_l)
			begin
				state_q <= state_idle;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state_q == state_idle) && miss)
		begin
			fill_addr_q <= miss_addr;
		end
	end

	// strobes for the arrays and the response, all one cycle behind the word
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			data_wr_q    <= 1'b0;
			tag_wr_q     <= 1'b0;
			resp_valid_q <= 1'b0;
		end
		else
		begin
			data_wr_q    <= word_in;
			tag_wr_q     <= last_in;
			resp_valid_q <= last_in;
		end
	end

	always_ff @(posedge clk)
	begin
		if (word_in)
		begin
			data_wr_addr_q <= {fill_addr_q.fields.set_idx, word_cnt_q};
			data_wr_data_q <= mem_data;
		end
		// keep the word that the missed request asked for
		if (word_in && (word_cnt_q == fill_addr_q.fields.word_idx))
		begin
			resp_data_q <= mem_data;
		end
	end

	assign data_wr         = data_wr_q;
	assign data_wr_addr    = data_wr_addr_q;
	assign data_wr_data    = data_wr_data_q;
	// the fill address holds still until the next miss, well after the tag write
	assign tag_wr          = tag_wr_q;
	assign tag_wr_set      = fill_addr_q.fields.set_idx;
	assign tag_wr_tag      = fill_addr_q.fields.tag;
	assign fill_resp_valid = resp_valid_q;
	assign fill_resp_data  = resp_data_q;

endmodule

// ==== hw/icache_top.sv ====
// top level of the direct-mapped read-only instruction cache
// a hit answers one cycle after req; a miss raises busy, reads the line
// from memory and answers in the cycle after the last word arrives
// requests may not be issued while busy is high
`timescale 1ns/1ps

module icache_top
	import icache_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic [addr_width-1:0] req_addr,
	input  logic                  invalidate_all,
	input  logic                  mem_data_valid,
	input  logic [data_width-1:0] mem_data,
	output logic                  busy,
	output logic                  resp_valid,
	output logic [data_width-1:0] resp_data,
	output logic                  mem_rd,
	output logic [addr_width-1:0] mem_addr
);

	localparam int data_entries_l = words_per_line << set_idx_width;

	cache_addr_t req_view;
	cache_addr_t cmp_addr_q;

	logic hit;
	logic miss;
	logic inval_en;

	logic                     tag_wr;
	logic [set_idx_width-1:0] tag_wr_set;
	logic [tag_width-1:0]     tag_wr_tag;

	logic                                    data_wr;
	logic [set_idx_width+word_idx_width-1:0] data_wr_addr;
	logic [data_width-1:0]                   data_wr_data;
	logic [data_width-1:0]                   hit_data;

	logic                  fill_resp_valid;
	logic [data_width-1:0] fill_resp_data;

	assign req_view.raw = req_addr;

	// invalidation would race with a running fill, so it is dropped while busy
	assign inval_en = invalidate_all && !busy;

	// address of the request now in its compare stage, handed on if it misses
	always_ff @(posedge clk)
	begin
		if (req)
		begin
			cmp_addr_q.raw <= req_addr;
		end
	end

	icache_tag_store u_tag_store (
		.clk            (clk),
		.rst_n          (rst_n),
		.lookup         (req),
		.lookup_addr    (req_view),
		.invalidate_all (inval_en),
		.tag_wr         (tag_wr),
		.tag_wr_set     (tag_wr_set),
		.tag_wr_tag     (tag_wr_tag),
		.hit            (hit),
		.miss           (miss)
	);

	// data is read in parallel with the tag so that a hit needs no extra cycle
	sram_1r1w #(
		.data_width_p (data_width),
		.size_p       (data_entries_l)
	) u_data_ram (
		.clk       (clk),
		.rd_enable (req),
		.rd_addr   ({req_view.fields.set_idx, req_view.fields.word_idx}),
		.rd_data   (hit_data),
		.wr_enable (data_wr),
		.wr_addr   (data_wr_addr),
		.wr_data   (data_wr_data)
	);

	icache_fill_ctrl u_fill_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.miss            (miss),
		.miss_addr       (cmp_addr_q),
		.mem_data_valid  (mem_data_valid),
		.mem_data        (mem_data),
		.busy            (busy),
		.mem_rd          (mem_rd),
		.mem_addr        (mem_addr),
		.data_wr         (data_wr),
		.data_wr_addr    (data_wr_addr),
		.data_wr_data    (data_wr_data),
		.tag_wr          (tag_wr),
		.tag_wr_set      (tag_wr_set),
		.tag_wr_tag      (tag_wr_tag),
		.fill_resp_valid (fill_resp_valid),
		.fill_resp_data  (fill_resp_data)
	);

	// a fill response and a hit never share a cycle, since no request can
	// be in its compare stage while the fill is still running
	assign resp_valid = hit || fill_resp_valid;
	assign resp_data  = fill_resp_valid ? fill_resp_data : hit_data;

endmodule

// ==== testbench/icache_assertions.sv ====
// protocol checks on the ports of the instruction cache top level
// bound into every icache_top instance, so the testbench needs no wiring for it
// each rule fails with $error when the cache or its requester breaks it
`timescale 1ns/1ps

module icache_assertions (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic busy,
	input logic resp_valid,
	input logic mem_rd
);

	// longest wait from a request to its response with the memory used here,
	// four words at six cycles each plus some margin
	localparam int resp_window_l = 40;

	// number of rule violations seen so far
	int fail_count = 0;

	// the requester has to hold off while a fill is running
	property req_only_when_idle;
		@(posedge clk) disable iff (!rst_n) req |-> !busy;
	endproperty

	// a line read only goes out in the cycle where busy comes up
	property mem_rd_on_busy_rise;
		@(posedge clk) disable iff (!rst_n) mem_rd |-> (busy && !$past(busy));
	endproperty

	// every request is answered, a hit after one cycle, a miss after its fill
	property resp_after_req;
		@(posedge clk) disable iff (!rst_n) req |-> ##[1:resp_window_l] resp_valid;
	endproperty

	// the cache comes out of reset idle
	property idle_after_reset;
		@(posedge clk) $rose(rst_n) |-> (!busy && !resp_valid && !mem_rd);
	endproperty

	assert property (req_only_when_idle)
	else
	begin
		fail_count++;
		$error("request issued while the cache is busy");
	end
	assert property (mem_rd_on_busy_rise)
	else
	begin
		fail_count++;
		$error("mem_rd pulsed outside the rising edge of busy");
	end
	assert property (resp_after_req)
	else
	begin
		fail_count++;
		$error("request was not answered by resp_valid");
	end
	assert property (idle_after_reset)
	else
	begin
		fail_count++;
		$error("cache is not idle after reset");
	end

endmodule

bind icache_top icache_assertions u_icache_assertions (
	.clk        (clk),
	.rst_n      (rst_n),
	.req        (req),
	.busy       (busy),
	.resp_valid (resp_valid),
	.mem_rd     (mem_rd)
);

// ==== testbench/icache_tb.sv ====
// testbench for the direct-mapped instruction cache
// drives directed and random requests into icache_top, acts as the line
// memory with a random latency between words, and checks every answer
// against a reference cache model kept in this file
// compile with the file list and run icache_tb as the top module
`timescale 1ns/1ps

module icache_tb
	import icache_pkg::*;
();

	localparam int sets_l = 1 << set_idx_width;
	localparam int reset_cycles = 2;
	// cycles between two returned words, and before the first one
	localparam int min_lat = 1;
	localparam int max_lat = 6;
	localparam int random_requests = 400;
	localparam int directed_requests = 20;
	// issue cycle, four words at the longest latency, then the response cycle
	localparam int request_worst_cycles = 2 + words_per_line * max_lat;
	// a random request may also bring an idle cycle and an invalidate
	localparam int run_worst_cycles = reset_cycles + 4 +
		(directed_requests + random_requests) * (request_worst_cycles + 2);
	localparam int timeout_cycles = 2 * run_worst_cycles;

	logic                  clk;
	logic                  rst_n;
	logic                  req;
	logic [addr_width-1:0] req_addr;
	logic                  invalidate_all;
	logic                  mem_data_valid;
	logic [data_width-1:0] mem_data;
	logic                  busy;
	logic                  resp_valid;
	logic [data_width-1:0] resp_data;
	logic                  mem_rd;
	logic [addr_width-1:0] mem_addr;

	// the reference model keeps one tag and one valid flag per set
	logic [tag_width-1:0] model_tag [sets_l];
	logic                 model_valid [sets_l];

	integer      seed;
	integer      cycle_count = 0;
	integer      check_count = 0;
	integer      error_count = 0;
	integer      test_checks;
	integer      test_errors;
	string       test_name;
	cache_addr_t rand_addr;
	int          pick;

	icache_top u_icache_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.req            (req),
		.req_addr       (req_addr),
		.invalidate_all (invalidate_all),
		.mem_data_valid (mem_data_valid),
		.mem_data       (mem_data),
		.busy           (busy),
		.resp_valid     (resp_valid),
		.resp_data      (resp_data),
		.mem_rd         (mem_rd),
		.mem_addr       (mem_addr)
	);

	always
	begin
		clk = 1'b0;
		#50;
		clk = 1'b1;
		#50;
	end

	// stops a run that hangs, at twice the longest possible run
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Error: run did not finish within %0d cycles", timeout_cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// contents of the backing memory, a scramble of the whole byte address
	function automatic logic [data_width-1:0] mem_word(input logic [addr_width-1:0] byte_addr);
		logic [31:0] x;
		begin
			x = byte_addr ^ 32'h3c6e_f372;
			x = x * 32'h9e37_79b1;
			return x ^ (x >> 15) ^ {byte_addr[15:0], byte_addr[31:16]};
		end
	endfunction

	// all stimulus changes 1 ns after the rising edge, and outputs are read
	// at that point too, once the edge has settled
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count = check_count + 1;
		assert (got === exp)
		else
		begin
			error_count = error_count + 1;
			$display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_checks = check_count;
		test_errors = error_count;
	endtask

	task automatic end_test();
		$display("test %s finished: %0d checks, %0d errors", test_name,
			check_count - test_checks, error_count - test_errors);
	endtask

	task automatic pulse_invalidate();
		invalidate_all = 1'b1;
		next_cycle();
		invalidate_all = 1'b0;
		for (int s = 0; s < sets_l; s++)
		begin
			model_valid[s] = 1'b0;
		end
	endtask

	// the memory side of a fill returns four words in order, each after a random gap
	// it ends in the cycle right after the last word, where the answer is due
	task automatic return_line(input logic [addr_width-1:0] line_addr);
		int lat;
		for (int w = 0; w < words_per_line; w++)
		begin
			lat = min_lat + ($unsigned($random(seed)) % (max_lat - min_lat + 1));
			repeat (lat)
			begin
				next_cycle();
				mem_data_valid = 1'b0;
				// no second line read and no early answer while the fill runs
				check_eq("mem_rd", mem_rd, 1'b0);
				check_eq("resp_valid", resp_valid, 1'b0);
			end
			mem_data_valid = 1'b1;
			mem_data       = mem_word(line_addr + 32'(w * 4));
		end
		next_cycle();
		mem_data_valid = 1'b0;
	endtask

	// one request from issue to answer, checked against the model
	task automatic issue_request(input logic [addr_width-1:0] addr);
		cache_addr_t           a;
		cache_addr_t           line;
		logic                  exp_hit;
		logic [data_width-1:0] exp_data;
		a.raw    = addr;
		line.raw = addr;
		line.fields.word_idx = '0;
		line.fields.byte_ofs = '0;
		exp_hit  = model_valid[a.fields.set_idx] && (model_tag[a.fields.set_idx] == a.fields.tag);
		exp_data = mem_word({addr[addr_width-1:2], 2'b00});
		check_eq("busy", busy, 1'b0);
		req      = 1'b1;
		req_addr = addr;
		next_cycle();
		req = 1'b0;
		// a miss shows up as a line read in the compare cycle
		check_eq("mem_rd", mem_rd, !exp_hit);
		if (mem_rd)
		begin
			check_eq("mem_addr", mem_addr, line.raw);
			check_eq("resp_valid", resp_valid, 1'b0);
			model_valid[a.fields.set_idx] = 1'b1;
			model_tag[a.fields.set_idx]   = a.fields.tag;
			return_line(mem_addr);
			check_eq("busy", busy, 1'b0);
		end
		check_eq("resp_valid", resp_valid, 1'b1);
		if (resp_valid)
		begin
			check_eq("resp_data", resp_data, exp_data);
		end
	endtask

	initial
	begin
		seed           = 32'h6b30_7a18;
		rst_n          = 1'b0;
		req            = 1'b0;
		req_addr       = '0;
		invalidate_all = 1'b0;
		mem_data_valid = 1'b0;
		mem_data       = '0;
		for (int s = 0; s < sets_l; s++)
		begin
			model_valid[s] = 1'b0;
			model_tag[s]   = '0;
		end
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;

		begin_test("reset");
		next_cycle();
		check_eq("busy", busy, 1'b0);
		check_eq("resp_valid", resp_valid, 1'b0);
		check_eq("mem_rd", mem_rd, 1'b0);
		end_test();

		begin_test("cold_miss");
		issue_request(32'h0001_2348);
		end_test();

		// the whole line just filled, back to back, then a fresh miss whose
		// line is hit in the cycle busy falls, which goes through the bypass
		begin_test("hit");
		for (int w = 0; w < words_per_line; w++)
		begin
			issue_request({28'h0001_234, 2'(w), 2'b00});
		end
		issue_request(32'h0004_5670);
		issue_request(32'h0004_5674);
		end_test();

		// both addresses fall in set 36 with different tags
		begin_test("conflict");
		for (int i = 0; i < 4; i++)
		begin
			issue_request(32'h0010_0a40);
			issue_request(32'h0020_0a44);
		end
		end_test();

		begin_test("invalidate");
		issue_request(32'h0001_2348);
		pulse_invalidate();
		issue_request(32'h0001_2348);
		issue_request(32'h0001_2344);
		end_test();

		// three tags over eight sets, so lines keep evicting each other
		begin_test("random_mix");
		for (int i = 0; i < random_requests; i++)
		begin
			if (($unsigned($random(seed)) % 25) == 0)
			begin
				pulse_invalidate();
			end
			if (($unsigned($random(seed)) % 4) == 0)
			begin
				next_cycle();
			end
			pick = $unsigned($random(seed)) % 3;
			rand_addr.raw = '0;
			rand_addr.fields.tag      = tag_width'(22'h01a5 + pick * 22'h0040);
			rand_addr.fields.set_idx  = set_idx_width'($unsigned($random(seed)) % 8);
			rand_addr.fields.word_idx = word_idx_width'($random(seed));
			issue_request(rand_addr.raw);
		end
		end_test();

		// protocol rule violations of the bound checker count as errors too
		error_count = error_count + u_icache_top.u_icache_assertions.fail_count;
		$display("total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
hw/icache_pkg.sv
hw/sram_1r1w.sv
hw/icache_tag_store.sv
hw/icache_fill_ctrl.sv
hw/icache_top.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv
